// File: include/rvParams_params.svh
`ifndef RV_PARAMS_PARAMS_SVH
`define RV_PARAMS_PARAMS_SVH

// Sizes of the RV32I integer slice

// Data path and address width
`define RV_XLEN 32

// Architectural registers x0 to x31
`define RV_REG_COUNT 32

// Register index width
`define RV_REG_ADDR_W 5

`endif

// File: src/rvPkg.sv
`default_nettype none

package rvPkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB
    } aluOp_e;

    // First ALU operand
    typedef enum logic {
        SRCA_REG,
        SRCA_PC
    } srcASel_e;

    // Write-back source, LINK is pc plus four
    typedef enum logic {
        RES_ALU,
        RES_LINK
    } resultSel_e;

    // Control-flow kind
    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_BRANCH,
        JMP_JAL,
        JMP_JALR
    } jumpKind_e;

    // Branch conditions in funct3 order
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } branchCmp_e;

endpackage

`default_nettype wire

// File: src/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvParams_params.svh"

module aluUnit import rvPkg::*;
(
    input  logic [`RV_XLEN-1:0] opA,
    input  logic [`RV_XLEN-1:0] opB,
    input  aluOp_e              aluOp,
    output logic [`RV_XLEN-1:0] result
);

    logic [4:0] shamt;

    // RV32I shifts use five bits only
    assign shamt = opB[4:0];

    always_comb
    begin
        case (aluOp)
            ALU_ADD:   result = opA + opB;
            ALU_SUB:   result = opA - opB;
            ALU_AND:   result = opA & opB;
            ALU_OR:    result = opA | opB;
            ALU_XOR:   result = opA ^ opB;
            ALU_SLL:   result = opA << shamt;
            ALU_SRL:   result = opA >> shamt;
            ALU_SRA:   result = $signed(opA) >>> shamt;
            // Set-less-than gives 0 or 1
            ALU_SLT:   result = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU:  result = {{(`RV_XLEN-1){1'b0}}, opA < opB};
            ALU_PASSB: result = opB;
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvParams_params.svh"

module regFile
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`RV_REG_ADDR_W-1:0] rs1,
    input  logic [`RV_REG_ADDR_W-1:0] rs2,
    input  logic                      wrEn,
    input  logic [`RV_REG_ADDR_W-1:0] wrAddr,
    input  logic [`RV_XLEN-1:0]       wrData,
    output logic [`RV_XLEN-1:0]       rs1Data,
    output logic [`RV_XLEN-1:0]       rs2Data
);

    // x1 to x31, x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wrEn && wrAddr != '0)
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Result being written is visible to the instruction decoded in the same cycle
    assign rs1Data = (rs1 == '0) ? '0 :
                     (wrEn && wrAddr == rs1) ? wrData : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 :
                     (wrEn && wrAddr == rs2) ? wrData : regs[rs2];

    // Decoder filters x0 destinations
    assert property (@(posedge clk) disable iff (rst) wrEn |-> (wrAddr != '0));

endmodule

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvParams_params.svh"

module instrDecoder import rvPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instrValid,
    input  logic [31:0]               instr,
    input  logic [`RV_XLEN-1:0]       pc,
    output logic                      decValid,
    output logic [`RV_XLEN-1:0]       decPc,
    output logic [`RV_REG_ADDR_W-1:0] rs1,
    output logic [`RV_REG_ADDR_W-1:0] rs2,
    output logic [`RV_REG_ADDR_W-1:0] rd,
    output logic [`RV_XLEN-1:0]       imm,
    output aluOp_e                    aluOp,
    output srcASel_e                  srcASel,
    output logic                      useImm,
    output logic                      regWrite,
    output resultSel_e                resultSel,
    output jumpKind_e                 jumpKind,
    output branchCmp_e                branchCmp,
    output logic                      illegal
);

    logic [31:0]         instrReg;
    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] immI;
    logic [`RV_XLEN-1:0] immU;
    logic [`RV_XLEN-1:0] immB;
    logic [`RV_XLEN-1:0] immJ;
    aluOp_e              baseOp;
    logic                writeReq;

    // Decode register, one instruction per cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            decValid <= 1'b0;
            instrReg <= '0;
            decPc    <= '0;
        end
        else
        begin
            decValid <= instrValid;
            instrReg <= instr;
            decPc    <= pc;
        end
    end

    // Instruction fields
    assign opcode = opcode_e'(instrReg[6:0]);
    assign rd     = instrReg[11:7];
    assign funct3 = instrReg[14:12];
    assign rs1    = instrReg[19:15];
    assign rs2    = instrReg[24:20];
    assign funct7 = instrReg[31:25];

    // Sign-extended immediates per format
    assign immI = {{(`RV_XLEN-12){instrReg[31]}}, instrReg[31:20]};
    assign immU = {instrReg[31:12], 12'b0};
    assign immB = {{(`RV_XLEN-13){instrReg[31]}}, instrReg[31], instrReg[7],
                   instrReg[30:25], instrReg[11:8], 1'b0};
    assign immJ = {{(`RV_XLEN-21){instrReg[31]}}, instrReg[31], instrReg[19:12],
                   instrReg[20], instrReg[30:21], 1'b0};

    // funct3 to ALU operation; SUB and SRA are patched in by funct7
    always_comb
    begin
        case (funct3)
            3'b000:  baseOp = ALU_ADD;
            3'b001:  baseOp = ALU_SLL;
            3'b010:  baseOp = ALU_SLT;
            3'b011:  baseOp = ALU_SLTU;
            3'b100:  baseOp = ALU_XOR;
            3'b101:  baseOp = ALU_SRL;
            3'b110:  baseOp = ALU_OR;
            default: baseOp = ALU_AND;
        endcase
    end

    // Control decode
    always_comb
    begin
        aluOp     = ALU_ADD;
        srcASel   = SRCA_REG;
        useImm    = 1'b0;
        writeReq  = 1'b0;
        resultSel = RES_ALU;
        jumpKind  = JMP_NONE;
        branchCmp = branchCmp_e'(funct3);
        illegal   = 1'b0;
        imm       = immI;

        case (opcode)
            OPC_OP:
            begin
                writeReq = 1'b1;
                if (funct7 == 7'b0000000)
                    aluOp = baseOp;
                else if (funct7 == 7'b0100000 && funct3 == 3'b000)
                    aluOp = ALU_SUB;
                else if (funct7 == 7'b0100000 && funct3 == 3'b101)
                    aluOp = ALU_SRA;
                else
                    illegal = 1'b1;
            end
            OPC_OP_IMM:
            begin
                writeReq = 1'b1;
                useImm   = 1'b1;
                aluOp    = baseOp;
                // Shift-immediates carry funct7 in the upper imm bits
                if (funct3 == 3'b001 && funct7 != 7'b0000000)
                    illegal = 1'b1;
                else if (funct3 == 3'b101 && funct7 == 7'b0100000)
                    aluOp = ALU_SRA;
                else if (funct3 == 3'b101 && funct7 != 7'b0000000)
                    illegal = 1'b1;
            end
            OPC_LUI:
            begin
                writeReq = 1'b1;
                useImm   = 1'b1;
                aluOp    = ALU_PASSB;
                imm      = immU;
            end
            OPC_AUIPC:
            begin
                writeReq = 1'b1;
                useImm   = 1'b1;
                srcASel  = SRCA_PC;
                imm      = immU;
            end
            OPC_JAL:
            begin
                writeReq  = 1'b1;
                resultSel = RES_LINK;
                jumpKind  = JMP_JAL;
                imm       = immJ;
            end
            OPC_JALR:
            begin
                writeReq  = 1'b1;
                resultSel = RES_LINK;
                jumpKind  = JMP_JALR;
                illegal   = (funct3 != 3'b000);
            end
            OPC_BRANCH:
            begin
                jumpKind = JMP_BRANCH;
                imm      = immB;
                // funct3 010 and 011 are not branches
                illegal  = (funct3[2:1] == 2'b01);
            end
            default:
            begin
                illegal = 1'b1;
            end
        endcase

        // x0 writes dropped here only
        regWrite = writeReq && !illegal && (rd != '0);

        // Illegal instructions must not redirect either
        if (illegal)
            jumpKind = JMP_NONE;
    end

    // Illegal never writes back
    assert property (@(posedge clk) disable iff (rst)
        decValid |-> !(illegal && regWrite));

endmodule

`default_nettype wire

// File: src/execStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvParams_params.svh"

module execStage import rvPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      decValid,
    input  logic [`RV_XLEN-1:0]       decPc,
    input  logic [`RV_REG_ADDR_W-1:0] rd,
    input  logic [`RV_XLEN-1:0]       imm,
    input  aluOp_e                    aluOp,
    input  srcASel_e                  srcASel,
    input  logic                      useImm,
    input  logic                      regWrite,
    input  resultSel_e                resultSel,
    input  jumpKind_e                 jumpKind,
    input  branchCmp_e                branchCmp,
    input  logic                      illegal,
    input  logic [`RV_XLEN-1:0]       rs1Data,
    input  logic [`RV_XLEN-1:0]       rs2Data,
    output logic                      wrEn,
    output logic [`RV_REG_ADDR_W-1:0] wrAddr,
    output logic [`RV_XLEN-1:0]       wrData,
    output logic                      redirectValid,
    output logic [`RV_XLEN-1:0]       redirectPc,
    output logic                      illegalValid
);

    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opB;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] jalrSum;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] linkValue;
    logic                cmpTrue;
    logic                taken;

    // Operand muxes
    assign opA = (srcASel == SRCA_PC) ? decPc : rs1Data;
    assign opB = useImm ? imm : rs2Data;

    aluUnit aluInst
    (
        .opA    (opA),
        .opB    (opB),
        .aluOp  (aluOp),
        .result (aluResult)
    );

    // Branch condition
    always_comb
    begin
        case (branchCmp)
            CMP_EQ:  cmpTrue = (rs1Data == rs2Data);
            CMP_NE:  cmpTrue = (rs1Data != rs2Data);
            CMP_LT:  cmpTrue = ($signed(rs1Data) < $signed(rs2Data));
            CMP_GE:  cmpTrue = ($signed(rs1Data) >= $signed(rs2Data));
            CMP_LTU: cmpTrue = (rs1Data < rs2Data);
            CMP_GEU: cmpTrue = (rs1Data >= rs2Data);
            default: cmpTrue = 1'b0;
        endcase
    end

    // Jumps always taken, branches on the compare
    assign taken = (jumpKind == JMP_JAL) || (jumpKind == JMP_JALR) ||
                   (jumpKind == JMP_BRANCH && cmpTrue);

    // JALR target has bit 0 cleared
    assign jalrSum   = rs1Data + imm;
    assign target    = (jumpKind == JMP_JALR) ? {jalrSum[`RV_XLEN-1:1], 1'b0} : decPc + imm;
    assign linkValue = decPc + `RV_XLEN'(4);

    // Strobes, one cycle after capture
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wrEn          <= 1'b0;
            redirectValid <= 1'b0;
            illegalValid  <= 1'b0;
        end
        else
        begin
            wrEn          <= decValid && regWrite && !illegal;
            redirectValid <= decValid && taken;
            illegalValid  <= decValid && illegal;
        end
    end

    // Payload
    always_ff @(posedge clk)
    begin
        wrAddr     <= rd;
        wrData     <= (resultSel == RES_LINK) ? linkValue : aluResult;
        redirectPc <= target;
    end

    // An illegal instruction never redirects
    assert property (@(posedge clk) disable iff (rst) !(redirectValid && illegalValid));

endmodule

`default_nettype wire

// File: src/decodeExecTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvParams_params.svh"

module decodeExecTop import rvPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instrValid,
    input  logic [31:0]               instr,
    input  logic [`RV_XLEN-1:0]       pc,
    output logic                      wbValid,
    output logic [`RV_REG_ADDR_W-1:0] wbRd,
    output logic [`RV_XLEN-1:0]       wbData,
    output logic                      redirectValid,
    output logic [`RV_XLEN-1:0]       redirectPc,
    output logic                      illegalValid
);

    // Decoded instruction
    logic                      decValid;
    logic [`RV_XLEN-1:0]       decPc;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       imm;
    aluOp_e                    aluOp;
    srcASel_e                  srcASel;
    logic                      useImm;
    logic                      regWrite;
    resultSel_e                resultSel;
    jumpKind_e                 jumpKind;
    branchCmp_e                branchCmp;
    logic                      illegal;

    // Operands
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;

    instrDecoder decInst
    (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .decValid   (decValid),
        .decPc      (decPc),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .aluOp      (aluOp),
        .srcASel    (srcASel),
        .useImm     (useImm),
        .regWrite   (regWrite),
        .resultSel  (resultSel),
        .jumpKind   (jumpKind),
        .branchCmp  (branchCmp),
        .illegal    (illegal)
    );

    // Write-back port doubles as the top-level result
    regFile rfInst
    (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .wrEn    (wbValid),
        .wrAddr  (wbRd),
        .wrData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    execStage exInst
    (
        .clk           (clk),
        .rst           (rst),
        .decValid      (decValid),
        .decPc         (decPc),
        .rd            (rd),
        .imm           (imm),
        .aluOp         (aluOp),
        .srcASel       (srcASel),
        .useImm        (useImm),
        .regWrite      (regWrite),
        .resultSel     (resultSel),
        .jumpKind      (jumpKind),
        .branchCmp     (branchCmp),
        .illegal       (illegal),
        .rs1Data       (rs1Data),
        .rs2Data       (rs2Data),
        .wrEn          (wbValid),
        .wrAddr        (wbRd),
        .wrData        (wbData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .illegalValid  (illegalValid)
    );

endmodule

`default_nettype wire

// File: test/decodeExecTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvParams_params.svh"

module decodeExecTb;

    localparam int resetCycles = 16;

    // Major opcodes used to assemble stimulus
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcAuipc  = 7'b0010111;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcJalr   = 7'b1100111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLoad   = 7'b0000011;

    // One row: stimulus plus expected strobes and payloads
    typedef struct packed {
        logic [31:0]               instr;
        logic [`RV_XLEN-1:0]       pc;
        logic                      wb;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       data;
        logic                      redir;
        logic [`RV_XLEN-1:0]       target;
        logic                      ill;
    } stimRow_t;

    logic                      clk;
    logic                      rst;
    logic                      instrValid;
    logic [31:0]               instr;
    logic [`RV_XLEN-1:0]       pc;
    logic                      wbValid;
    logic [`RV_REG_ADDR_W-1:0] wbRd;
    logic [`RV_XLEN-1:0]       wbData;
    logic                      redirectValid;
    logic [`RV_XLEN-1:0]       redirectPc;
    logic                      illegalValid;

    stimRow_t stimTable[$];
    logic     tableReady = 1'b0;
    int       errorCount = 0;
    int       checkCount = 0;

    decodeExecTop dut_i
    (
        .clk           (clk),
        .rst           (rst),
        .instrValid    (instrValid),
        .instr         (instr),
        .pc            (pc),
        .wbValid       (wbValid),
        .wbRd          (wbRd),
        .wbData        (wbData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .illegalValid  (illegalValid)
    );

    // 4 ns clock
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // RV32I encoders, standard field layout
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opcOp};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // Offset bit 0 is implied zero
    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opcJal};
    endfunction

    task automatic addRow(input logic [31:0] ins, input logic [31:0] p, input logic wb,
                          input logic [4:0] rd, input logic [31:0] data, input logic redir,
                          input logic [31:0] target, input logic ill);
        stimRow_t r;
        r = '{ins, p, wb, rd, data, redir, target, ill};
        stimTable.push_back(r);
    endtask

    task automatic wbRow(input logic [31:0] ins, input logic [31:0] p,
                         input logic [4:0] rd, input logic [31:0] data);
        addRow(ins, p, 1'b1, rd, data, 1'b0, '0, 1'b0);
    endtask

    task automatic branchRow(input logic [31:0] ins, input logic [31:0] p,
                             input logic taken, input logic [31:0] target);
        addRow(ins, p, 1'b0, '0, '0, taken, target, 1'b0);
    endtask

    // Expected values worked out by hand from the RV32I rules
    task automatic buildTable();
        wbRow(encI(12'hFFB, 5'd0, 3'b000, 5'd1, opcOpImm), 32'h100, 5'd1, 32'hFFFF_FFFB);
        wbRow(encU(20'h00001, 5'd3, opcAuipc), 32'h104, 5'd3, 32'h0000_1104);
        wbRow(encI(12'h003, 5'd0, 3'b000, 5'd4, opcOpImm), 32'h108, 5'd4, 32'h3);
        wbRow(encU(20'h12345, 5'd2, opcLui), 32'h10C, 5'd2, 32'h1234_5000);
        // Dependent chain, each row reads the previous result
        wbRow(encR(7'h00, 5'd1, 5'd2, 3'b000, 5'd5), 32'h110, 5'd5, 32'h1234_4FFB);
        wbRow(encR(7'h20, 5'd4, 5'd5, 3'b000, 5'd6), 32'h114, 5'd6, 32'h1234_4FF8);
        wbRow(encR(7'h00, 5'd4, 5'd6, 3'b001, 5'd7), 32'h118, 5'd7, 32'h91A2_7FC0);
        wbRow(encR(7'h20, 5'd4, 5'd7, 3'b101, 5'd8), 32'h11C, 5'd8, 32'hF234_4FF8);
        wbRow(encR(7'h00, 5'd4, 5'd8, 3'b101, 5'd9), 32'h120, 5'd9, 32'h1E46_89FF);
        wbRow(encR(7'h00, 5'd1, 5'd9, 3'b100, 5'd10), 32'h124, 5'd10, 32'hE1B9_7604);
        wbRow(encR(7'h00, 5'd4, 5'd10, 3'b110, 5'd11), 32'h128, 5'd11, 32'hE1B9_7607);
        wbRow(encR(7'h00, 5'd2, 5'd11, 3'b111, 5'd12), 32'h12C, 5'd12, 32'h0030_5000);
        wbRow(encR(7'h00, 5'd12, 5'd1, 3'b010, 5'd13), 32'h130, 5'd13, 32'h1);
        // Unsigned compare of 1 against -5
        wbRow(encR(7'h00, 5'd1, 5'd13, 3'b011, 5'd14), 32'h134, 5'd14, 32'h1);
        // Branches, x1 = -5, x4 = 3, x13 = x14 = 1
        branchRow(encB(13'd16, 5'd14, 5'd13, 3'b000), 32'h200, 1'b1, 32'h210);
        branchRow(encB(13'd16, 5'd4, 5'd1, 3'b000), 32'h204, 1'b0, '0);
        branchRow(encB(13'h1FF8, 5'd4, 5'd1, 3'b001), 32'h208, 1'b1, 32'h200);
        branchRow(encB(13'h1FF8, 5'd14, 5'd13, 3'b001), 32'h20C, 1'b0, '0);
        branchRow(encB(13'd32, 5'd4, 5'd1, 3'b100), 32'h210, 1'b1, 32'h230);
        branchRow(encB(13'd32, 5'd1, 5'd4, 3'b100), 32'h214, 1'b0, '0);
        branchRow(encB(13'd12, 5'd1, 5'd4, 3'b101), 32'h218, 1'b1, 32'h224);
        branchRow(encB(13'd12, 5'd4, 5'd1, 3'b101), 32'h21C, 1'b0, '0);
        branchRow(encB(13'h100, 5'd1, 5'd4, 3'b110), 32'h220, 1'b1, 32'h320);
        branchRow(encB(13'h100, 5'd4, 5'd1, 3'b110), 32'h224, 1'b0, '0);
        branchRow(encB(13'd20, 5'd4, 5'd1, 3'b111), 32'h228, 1'b1, 32'h23C);
        branchRow(encB(13'd20, 5'd1, 5'd4, 3'b111), 32'h22C, 1'b0, '0);
        // Jumps link and redirect in the same cycle
        addRow(encJ(21'h40, 5'd15), 32'h300, 1'b1, 5'd15, 32'h304, 1'b1, 32'h340, 1'b0);
        addRow(encI(12'h007, 5'd2, 3'b000, 5'd16, opcJalr), 32'h400, 1'b1, 5'd16, 32'h404,
               1'b1, 32'h1234_5006, 1'b0);
        // Load is outside the kept set
        addRow(encI(12'h000, 5'd0, 3'b010, 5'd17, opcLoad), 32'h500, 1'b0, '0, '0, 1'b0, '0,
               1'b1);
        // Write to x0 is silent, then x0 reads back as zero
        addRow(encI(12'h055, 5'd0, 3'b000, 5'd0, opcOpImm), 32'h504, 1'b0, '0, '0, 1'b0, '0,
               1'b0);
        wbRow(encR(7'h00, 5'd4, 5'd0, 3'b000, 5'd18), 32'h508, 5'd18, 32'h3);
    endtask

    task automatic checkWb(input int row, input logic expValid,
                           input logic [`RV_REG_ADDR_W-1:0] expRd,
                           input logic [`RV_XLEN-1:0] expData);
        checkCount++;
        if (wbValid !== expValid)
        begin
            errorCount++;
            $display("[ERROR] row %0d wbValid exp %h got %h", row, expValid, wbValid);
        end
        else if (expValid && (wbRd !== expRd || wbData !== expData))
        begin
            errorCount++;
            $display("[ERROR] row %0d wbRd exp %h got %h, wbData exp %h got %h",
                     row, expRd, wbRd, expData, wbData);
        end
    endtask

    task automatic checkRedirect(input int row, input logic expValid,
                                 input logic [`RV_XLEN-1:0] expPc);
        checkCount++;
        if (redirectValid !== expValid)
        begin
            errorCount++;
            $display("[ERROR] row %0d redirectValid exp %h got %h", row, expValid,
                     redirectValid);
        end
        else if (expValid && redirectPc !== expPc)
        begin
            errorCount++;
            $display("[ERROR] row %0d redirectPc exp %h got %h", row, expPc, redirectPc);
        end
    endtask

    task automatic checkIllegal(input int row, input logic expValid);
        checkCount++;
        if (illegalValid !== expValid)
        begin
            errorCount++;
            $display("[ERROR] row %0d illegalValid exp %h got %h", row, expValid,
                     illegalValid);
        end
    endtask

    // Nothing may come out while idle
    task automatic checkQuiet(input int row);
        checkWb(row, 1'b0, '0, '0);
        checkRedirect(row, 1'b0, '0);
        checkIllegal(row, 1'b0);
    endtask

    // Bounded by reset, table length and some slack
    initial
    begin : watchdog
        int cycles;
        int cycleLimit;
        cycles = 0;
        wait (tableReady);
        cycleLimit = resetCycles + stimTable.size() + 20;
        while (cycles < cycleLimit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", cycleLimit);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin : mainFlow
        int       i;
        int       numRows;
        stimRow_t r;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        buildTable();
        numRows    = stimTable.size();
        tableReady = 1'b1;

        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            checkQuiet(-1);
        end

        // Row i sampled one edge after the drive, result one edge later
        for (i = 0; i < numRows + 2; i++)
        begin
            @(posedge clk);
            if (i < numRows)
            begin
                instrValid <= 1'b1;
                instr      <= stimTable[i].instr;
                pc         <= stimTable[i].pc;
            end
            else
            begin
                instrValid <= 1'b0;
                instr      <= '0;
                pc         <= '0;
            end
            @(negedge clk);
            if (i < 2)
            begin
                checkQuiet(-1);
            end
            else
            begin
                r = stimTable[i-2];
                checkWb(i - 2, r.wb, r.rd, r.data);
                checkRedirect(i - 2, r.redir, r.target);
                checkIllegal(i - 2, r.ill);
            end
        end

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
src/rvPkg.sv
src/aluUnit.sv
src/regFile.sv
src/instrDecoder.sv
src/execStage.sv
src/decodeExecTop.sv
test/decodeExecTb.sv
